// ==== compile.f ====
rtl/mips_pkg.sv
rtl/pipe_reg.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_stage.sv
rtl/mips_core.sv
tests/tb_clock.sv
tests/tb_mips_core.sv

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  logic [31:0]       instr,
    input  logic              ex_valid,
    input  logic [4:0]        ex_load_dest,
    input  mips_pkg::mem_wb_t wb_in,
    output logic              id_valid,
    output mips_pkg::id_ex_t  id_out
);
    import mips_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  dest;
    logic        uses_rt;
    logic        hazard;
    logic [31:0] regs [1:31];
    ex_ctrl_t    ex_ctrl;
    mem_ctrl_t   mem_ctrl;
    wb_ctrl_t    wb_ctrl;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = instr[5:0];

    // Read with write-through from the MEM/WB register write
    function automatic logic [31:0] read_reg(input logic [4:0] addr);
        logic [31:0] value;
        if (addr == 5'd0) begin
            value = '0;
        end else if (wb_in.reg_write && wb_in.dest == addr) begin
            value = wb_in.result;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        ex_ctrl  = '{alu_op: FUNCT_ADD, reg_dst: 1'b0, alu_src: 1'b0};
        mem_ctrl = '0;
        wb_ctrl  = '0;
        uses_rt  = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                ex_ctrl.alu_op    = funct;
                ex_ctrl.reg_dst   = 1'b1;
                wb_ctrl.reg_write = 1'b1;
                uses_rt           = 1'b1;
            end
            OP_ADDI: begin
                ex_ctrl.alu_src   = 1'b1;
                wb_ctrl.reg_write = 1'b1;
            end
            OP_LW: begin
                ex_ctrl.alu_src    = 1'b1;
                mem_ctrl.mem_read  = 1'b1;
                wb_ctrl.reg_write  = 1'b1;
                wb_ctrl.mem_to_reg = 1'b1;
            end
            OP_SW: begin
                ex_ctrl.alu_src    = 1'b1;
                mem_ctrl.mem_write = 1'b1;
                uses_rt            = 1'b1;
            end
            default: ;
        endcase
        dest = ex_ctrl.reg_dst ? rd : rt;
        // Writes to r0 are dropped here
        if (dest == 5'd0) begin
            wb_ctrl.reg_write = 1'b0;
        end
    end

    // Register file, r0 is not stored
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_in.reg_write && wb_in.dest != 5'd0) begin
            regs[wb_in.dest] <= wb_in.result;
        end
    end

    // Load in ID/EX feeding this instruction
    assign hazard = ex_valid && (ex_load_dest != 5'd0) &&
                    ((ex_load_dest == rs) || (uses_rt && ex_load_dest == rt));
    assign in_ready = !hazard;
    assign id_valid = in_valid && in_ready;

    always_comb begin
        id_out.ex          = ex_ctrl;
        id_out.mem         = mem_ctrl;
        id_out.wb          = wb_ctrl;
        id_out.data1       = read_reg(rs);
        id_out.data2       = read_reg(rt);
        id_out.sign_extend = {{16{instr[15]}}, instr[15:0]};
        id_out.rs          = rs;
        id_out.rt          = rt;
        id_out.rd          = rd;
    end

    // One bubble always clears the hazard
    a_single_stall: assert property (
        @(posedge clk) disable iff (rst)
        !in_ready |=> in_ready
    );

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic              id_valid,
    input  mips_pkg::id_ex_t  id_in,
    input  mips_pkg::ex_mem_t mem_fwd,
    input  logic              mem_fwd_valid,
    input  mips_pkg::mem_wb_t wb_fwd,
    output mips_pkg::ex_mem_t ex_out
);
    import mips_pkg::*;

    logic [31:0] op_a;
    logic [31:0] fwd_b;
    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic [4:0]  dest;

    // Youngest producer wins, so EX/MEM goes before MEM/WB and the register value
    function automatic logic [31:0] forward(
        input logic [4:0]  src,
        input logic [31:0] reg_value
    );
        logic [31:0] value;
        if (mem_fwd_valid && mem_fwd.wb.reg_write &&
            mem_fwd.dest != 5'd0 && mem_fwd.dest == src) begin
            value = mem_fwd.alu_result;
        end else if (wb_fwd.reg_write && wb_fwd.dest != 5'd0 && wb_fwd.dest == src) begin
            value = wb_fwd.result;
        end else begin
            value = reg_value;
        end
        return value;
    endfunction

    always_comb begin
        op_a  = forward(id_in.rs, id_in.data1);
        fwd_b = forward(id_in.rt, id_in.data2);
        op_b  = id_in.ex.alu_src ? id_in.sign_extend : fwd_b;
    end

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (id_in.ex.alu_op)
            FUNCT_ADD: alu_result = op_a + op_b;
            FUNCT_SUB: alu_result = op_a - op_b;
            FUNCT_AND: alu_result = op_a & op_b;
            FUNCT_OR:  alu_result = op_a | op_b;
            // Signed compare
            FUNCT_SLT: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            default:   alu_result = '0;
        endcase
    end

    assign dest = id_in.ex.reg_dst ? id_in.rd : id_in.rt;

    // Bubbles carry no side effects downstream
    always_comb begin
        ex_out.mem        = id_valid ? id_in.mem : '0;
        ex_out.wb         = id_valid ? id_in.wb : '0;
        ex_out.alu_result = alu_result;
        ex_out.store_data = fwd_b;
        ex_out.dest       = dest;
    end

endmodule

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic              clk,
    input  logic              mem_valid,
    input  mips_pkg::ex_mem_t mem_in,
    output mips_pkg::mem_wb_t wb_out
);

    localparam int AW = $clog2(DMEM_DEPTH);

    logic [31:0]   dmem [DMEM_DEPTH] = '{default: '0};
    logic [AW-1:0] word_addr;
    logic [31:0]   load_data;

    // Byte address to word index
    assign word_addr = mem_in.alu_result[AW+1:2];
    assign load_data = dmem[word_addr];

    always_ff @(posedge clk) begin
        if (mem_valid && mem_in.mem.mem_write) begin
            dmem[word_addr] <= mem_in.store_data;
        end
    end

    // Load data or ALU result
    assign wb_out.reg_write = mem_in.wb.reg_write;
    assign wb_out.dest      = mem_in.dest;
    assign wb_out.result    = mem_in.wb.mem_to_reg ? load_data : mem_in.alu_result;

    a_addr_legal: assert property (
        @(posedge clk)
        (mem_valid && (mem_in.mem.mem_read || mem_in.mem.mem_write)) |->
            (mem_in.alu_result[1:0] == 2'b00 &&
             mem_in.alu_result < 32'(4 * DMEM_DEPTH))
    );

endmodule

// ==== rtl/mips_core.sv ====
`timescale 1ns/1ps

module mips_core #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [31:0] instr,
    output logic        wb_valid,
    output logic [4:0]  wb_reg,
    output logic [31:0] wb_data
);
    import mips_pkg::*;

    logic        id_valid;
    id_ex_t      id_d;
    logic        id_ex_valid;
    id_ex_t      id_ex_q;
    ex_mem_t     ex_d;
    logic        ex_mem_valid;
    ex_mem_t     ex_mem_q;
    mem_wb_t     mem_d;
    logic        mem_wb_valid;
    mem_wb_t     mem_wb_q;
    mem_wb_t     wb_commit;
    logic [4:0]  ex_load_dest;

    // Load destination seen by the hazard check
    assign ex_load_dest = id_ex_q.mem.mem_read ? id_ex_q.rt : 5'd0;

    // Retiring write, masked by the MEM/WB valid bit
    assign wb_commit.reg_write = mem_wb_valid && mem_wb_q.reg_write;
    assign wb_commit.dest      = mem_wb_q.dest;
    assign wb_commit.result    = mem_wb_q.result;

    assign wb_valid = wb_commit.reg_write;
    assign wb_reg   = wb_commit.dest;
    assign wb_data  = wb_commit.result;

    ////////////////////////////////////////////////////////////////////////////
    // Stages and latches
    ////////////////////////////////////////////////////////////////////////////

    decode_stage u_decode (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .instr        (instr),
        .ex_valid     (id_ex_valid),
        .ex_load_dest (ex_load_dest),
        .wb_in        (wb_commit),
        .id_valid     (id_valid),
        .id_out       (id_d)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (id_valid),
        .in_data   (id_d),
        .out_valid (id_ex_valid),
        .out_data  (id_ex_q)
    );

    execute_stage u_execute (
        .id_valid      (id_ex_valid),
        .id_in         (id_ex_q),
        .mem_fwd       (ex_mem_q),
        .mem_fwd_valid (ex_mem_valid),
        .wb_fwd        (wb_commit),
        .ex_out        (ex_d)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (id_ex_valid),
        .in_data   (ex_d),
        .out_valid (ex_mem_valid),
        .out_data  (ex_mem_q)
    );

    mem_stage #(.DMEM_DEPTH(DMEM_DEPTH)) u_mem (
        .clk       (clk),
        .mem_valid (ex_mem_valid),
        .mem_in    (ex_mem_q),
        .wb_out    (mem_d)
    );

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (ex_mem_valid),
        .in_data   (mem_d),
        .out_valid (mem_wb_valid),
        .out_data  (mem_wb_q)
    );

endmodule

// ==== rtl/mips_pkg.sv ====
package mips_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////////////////////

    // Primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type funct codes, reused as the ALU operation
    localparam logic [5:0] FUNCT_ADD = 6'h20;
    localparam logic [5:0] FUNCT_SUB = 6'h22;
    localparam logic [5:0] FUNCT_AND = 6'h24;
    localparam logic [5:0] FUNCT_OR  = 6'h25;
    localparam logic [5:0] FUNCT_SLT = 6'h2a;

    ////////////////////////////////////////////////////////////////////////////
    // Control groups
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [5:0] alu_op;
        logic       reg_dst;
        logic       alu_src;
    } ex_ctrl_t;

    typedef struct packed {
        logic mem_write;
        logic mem_read;
    } mem_ctrl_t;

    typedef struct packed {
        logic reg_write;
        logic mem_to_reg;
    } wb_ctrl_t;

    ////////////////////////////////////////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        ex_ctrl_t    ex;
        mem_ctrl_t   mem;
        wb_ctrl_t    wb;
        logic [31:0] data1;
        logic [31:0] data2;
        logic [31:0] sign_extend;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
    } id_ex_t;

    typedef struct packed {
        mem_ctrl_t   mem;
        wb_ctrl_t    wb;
        logic [31:0] alu_result;
        logic [31:0] store_data;
        logic [4:0]  dest;
    } ex_mem_t;

    // Register write as seen by the register file and the port
    typedef struct packed {
        logic        reg_write;
        logic [4:0]  dest;
        logic [31:0] result;
    } mem_wb_t;

endpackage

// ==== rtl/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // Valid bit, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Payload only moves with a real entry, bubbles leave it alone
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

    a_valid_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(out_valid)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then search the log for the fail message
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_mips_core -f compile.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    && ! grep -q "Test failed" sim.log \
    || { cat sim.log 2>/dev/null; echo "Simulation failed, see sim.log"; exit 1; }
cat sim.log
echo "Simulation passed"

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset held for a fixed number of rising edges
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== tests/tb_mips_core.sv ====
`timescale 1ns/1ps

module tb_mips_core;
    import mips_pkg::*;

    localparam int N_RTYPE     = 28;
    localparam int N_ADDI      = 8;
    localparam int N_FWD       = 18;
    localparam int N_MEM       = 8;
    localparam int N_STALL     = 5;
    localparam int N_ZERO      = 4;
    localparam int TOTAL_INSTR = N_RTYPE + N_ADDI + N_FWD + N_MEM + N_STALL + N_ZERO;

    typedef struct packed {
        logic [4:0]  dest;
        logic [31:0] value;
    } wb_exp_t;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] instr;
    logic        wb_valid;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;

    logic [31:0] shadow_reg [32] = '{default: '0};
    logic [31:0] shadow_mem [64] = '{default: '0};
    wb_exp_t     exp_q [$];
    wb_exp_t     exp_head = '0;
    logic        acc_now = 1'b0;
    logic [2:0]  acc_pipe;
    logic        no_stall = 1'b0;
    logic [15:0] lfsr_state = 16'd90;
    int          assert_errors = 0;
    int          retire_errors = 0;
    int          stall_errors = 0;
    int          test_errors = 0;
    int          passed_tests = 0;
    int          failed_tests = 0;

    tb_clock #(.PERIOD(20), .RESET_CYCLES(5)) u_clock (
        .clk (clk),
        .rst (rst)
    );

    mips_core #(.DMEM_DEPTH(64)) dut (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .instr    (instr),
        .wb_valid (wb_valid),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Random numbers and instruction encoding
    ////////////////////////////////////////////////////////////////////////////

    // Galois LFSR, one step per bit
    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    // One of eight registers starting at base
    function automatic logic [4:0] random_reg(input logic [4:0] base);
        return base + 5'(random_bits(3));
    endfunction

    function automatic logic [5:0] random_funct();
        logic [2:0] pick;
        pick = 3'(random_bits(3));
        case (pick)
            3'd0, 3'd5: return FUNCT_ADD;
            3'd1, 3'd6: return FUNCT_SUB;
            3'd2, 3'd7: return FUNCT_AND;
            3'd3:       return FUNCT_OR;
            default:    return FUNCT_SLT;
        endcase
    endfunction

    function automatic logic [31:0] encode_rtype(input logic [5:0] funct,
                                                 input logic [4:0] rd,
                                                 input logic [4:0] rs,
                                                 input logic [4:0] rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encode_itype(input logic [5:0] op,
                                                 input logic [4:0] rt,
                                                 input logic [4:0] rs,
                                                 input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Register write expected from this word, r0 excluded
    function automatic logic writes_reg(input logic [31:0] word);
        logic [4:0] dest;
        logic       writes;
        dest   = (word[31:26] == OP_RTYPE) ? word[15:11] : word[20:16];
        writes = word[31:26] inside {OP_RTYPE, OP_ADDI, OP_LW};
        return writes && dest != 5'd0;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model, run in program order at acceptance
    ////////////////////////////////////////////////////////////////////////////

    function automatic void model_accept(input logic [31:0] word);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] result;
        logic [4:0]  dest;
        logic        writes;
        wb_exp_t     entry;
        a      = shadow_reg[word[25:21]];
        b      = shadow_reg[word[20:16]];
        imm    = {{16{word[15]}}, word[15:0]};
        addr   = a + imm;
        result = '0;
        dest   = word[20:16];
        writes = 1'b1;
        case (word[31:26])
            OP_RTYPE: begin
                dest = word[15:11];
                case (word[5:0])
                    FUNCT_ADD: result = a + b;
                    FUNCT_SUB: result = a - b;
                    FUNCT_AND: result = a & b;
                    FUNCT_OR:  result = a | b;
                    default:   result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                endcase
            end
            OP_ADDI: result = addr;
            OP_LW:   result = shadow_mem[addr[7:2]];
            OP_SW: begin
                shadow_mem[addr[7:2]] = b;
                writes = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        if (writes && dest != 5'd0) begin
            shadow_reg[dest] = result;
            entry.dest  = dest;
            entry.value = result;
            exp_q.push_back(entry);
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Driver and test bookkeeping
    ////////////////////////////////////////////////////////////////////////////

    // Called just after a rising edge, returns on the accepting edge
    task automatic issue(input logic [31:0] word, output int stalls);
        stalls = 0;
        in_valid <= 1'b1;
        instr    <= word;
        @(negedge clk);
        while (!in_ready) begin
            stalls++;
            @(negedge clk);
        end
        model_accept(word);
        @(posedge clk);
    endtask

    task automatic send(input logic [31:0] word);
        int stalls;
        issue(word, stalls);
    endtask

    task automatic expect_one_stall(input int stalls);
        a_one_stall: assert (stalls == 1) else begin
            $display("Load-use hazard held in_ready low for %0d cycles instead of one", stalls);
            stall_errors++;
        end
    endtask

    function automatic int total_errors();
        return assert_errors + retire_errors + stall_errors;
    endfunction

    // Drain the pipeline, then report
    task automatic end_test(input string name);
        in_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        no_stall = 1'b0;
        if (total_errors() == test_errors) begin
            $display("%s: passed", name);
            passed_tests++;
        end else begin
            $display("%s: FAILED with %0d errors", name, total_errors() - test_errors);
            failed_tests++;
        end
        test_errors = total_errors();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Expected retirement
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            acc_pipe <= '0;
        end else begin
            acc_pipe <= {acc_pipe[1:0], acc_now};
        end
    end

    // Inputs and outputs only move on rising edges, so these are settled here
    always @(negedge clk) begin
        acc_now = in_valid && in_ready && writes_reg(instr);
        if (!rst && wb_valid) begin
            a_write_expected: assert (exp_q.size() != 0) else begin
                $display("At %0t the DUT retired a write the model did not expect", $time);
                retire_errors++;
            end
            if (exp_q.size() != 0) begin
                exp_head = exp_q.pop_front();
            end
        end
    end

    a_wb_latency: assert property (@(posedge clk) disable iff (rst) wb_valid == acc_pipe[2])
        else begin
            $display("Error at %0t: wb_valid expected %0b got %0b",
                     $time, $sampled(acc_pipe[2]), $sampled(wb_valid));
            assert_errors++;
        end

    a_wb_reg: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> wb_reg == exp_head.dest)
        else begin
            $display("Error at %0t: wb_reg expected %0d got %0d",
                     $time, $sampled(exp_head.dest), $sampled(wb_reg));
            assert_errors++;
        end

    a_wb_data: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> wb_data == exp_head.value)
        else begin
            $display("Error at %0t: wb_data expected %h got %h",
                     $time, $sampled(exp_head.value), $sampled(wb_data));
            assert_errors++;
        end

    a_no_stall: assert property (@(posedge clk) disable iff (rst)
        (no_stall && in_valid) |-> in_ready)
        else begin
            $display("At %0t in_ready dropped during a forwarding chain", $time);
            assert_errors++;
        end

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int          stalls;
        logic [4:0]  src;
        logic [15:0] imm;
        in_valid = 1'b0;
        instr    = '0;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end

        // Preload r1..r8, then random R-type
        for (int i = 1; i <= 8; i++) begin
            send(encode_itype(OP_ADDI, 5'(i), 5'd0, 16'(random_bits(16))));
        end
        for (int i = 0; i < N_RTYPE - 8; i++) begin
            send(encode_rtype(random_funct(), 5'(random_bits(5)),
                              random_reg(5'd1), random_reg(5'd1)));
        end
        end_test("R-type results");

        for (int i = 0; i < N_ADDI; i++) begin
            imm = {1'b1, 15'(random_bits(15))};
            send(encode_itype(OP_ADDI, random_reg(5'd9), random_reg(5'd1), imm));
        end
        end_test("ADDI sign extension");

        // Instruction k reads the result of instruction k-d
        no_stall = 1'b1;
        for (int d = 1; d <= 3; d++) begin
            for (int k = 0; k < 6; k++) begin
                src = (k >= d) ? 5'(16 + k - d) : random_reg(5'd1);
                send(encode_rtype(random_funct(), 5'(16 + k), src, random_reg(5'd1)));
            end
        end
        end_test("Forwarding chains");

        for (int i = 0; i < N_MEM / 2; i++) begin
            imm = {8'd0, 6'(random_bits(6)), 2'b00};
            send(encode_itype(OP_SW, random_reg(5'd1), 5'd0, imm));
            send(encode_itype(OP_LW, 5'(24 + i), 5'd0, imm));
        end
        end_test("Memory round trip");

        // Dependence through rs, then through rt
        send(encode_itype(OP_SW, 5'd5, 5'd0, 16'd40));
        send(encode_itype(OP_LW, 5'd20, 5'd0, 16'd40));
        issue(encode_rtype(FUNCT_ADD, 5'd21, 5'd20, 5'd3), stalls);
        expect_one_stall(stalls);
        send(encode_itype(OP_LW, 5'd22, 5'd0, 16'd40));
        issue(encode_rtype(FUNCT_SUB, 5'd23, 5'd1, 5'd22), stalls);
        expect_one_stall(stalls);
        end_test("Load-use stall");

        send(encode_itype(OP_ADDI, 5'd0, 5'd1, 16'h1234));
        send(encode_rtype(FUNCT_ADD, 5'd0, 5'd1, 5'd2));
        send(encode_rtype(FUNCT_ADD, 5'd25, 5'd0, 5'd3));
        send(encode_rtype(FUNCT_OR, 5'd26, 5'd0, 5'd0));
        end_test("Register zero");

        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 passed_tests, failed_tests, total_errors());
        if (failed_tests == 0 && total_errors() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Four cycles per instruction plus margin for reset and drains
    initial begin
        repeat (TOTAL_INSTR * 4 + 200) @(posedge clk);
        $display("Watchdog expired after %0d cycles without the tests finishing",
                 TOTAL_INSTR * 4 + 200);
        $display("Test failed");
        $finish;
    end

endmodule
